/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := bb_tb
FILELIST  := bb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bb.f */
verilog/bb_pkg.sv
verilog/bb_apb_decode.sv
verilog/bb_adc_channel.sv
verilog/bb_dds.sv
verilog/bb_dac_channel.sv
verilog/bb_ioexp_result.sv
verilog/bb_top.sv
testbench/bb_chk.sv
testbench/bb_tb.sv

/* testbench/bb_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module bb_chk (
    input wire                        clk,
    input wire                        rst_i,
    input wire bb_pkg::apb_req_t      apb_i,
    input wire bb_pkg::sample_t       dac_a_o,
    input wire bb_pkg::sample_t       dac_b_o,
    input wire bb_pkg::chan_status_t  st_ina,
    input wire bb_pkg::chan_status_t  st_inb,
    input wire [15:0]                 adc_io_o
);

    //////////////////////////////////////////////////////////////////////
    // APB protocol
    //////////////////////////////////////////////////////////////////////

    penable_needs_psel: assert property (@(posedge clk) disable iff (rst_i)
        apb_i.penable |-> apb_i.psel)
        else $error("PENABLE high without PSEL");

    // DAC outputs cleared by reset
    dac_zero_after_reset: assert property (@(posedge clk)
        rst_i |=> (dac_a_o == 8'h00 && dac_b_o == 8'h00))
        else $error("DAC output not zero after reset");

    // Red only, active low LED bits read 011
    dor_a_red_only: assert property (@(posedge clk) disable iff (rst_i)
        st_ina.dor |=> adc_io_o[5:3] == 3'b011)
        else $error("ADC A overrange LED pattern wrong");

    dor_b_red_only: assert property (@(posedge clk) disable iff (rst_i)
        st_inb.dor |=> adc_io_o[13:11] == 3'b011)
        else $error("ADC B overrange LED pattern wrong");

endmodule

bind bb_top bb_chk chk_i (
    .clk(clk), .rst_i(rst_i), .apb_i(apb_i), .dac_a_o(dac_a_o), .dac_b_o(dac_b_o),
    .st_ina(st_ina), .st_inb(st_inb), .adc_io_o(adc_io_o)
);

`default_nettype wire

/* testbench/bb_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module bb_tb;

    localparam int CLK_NS     = 10;
    localparam int RST_CYCLES = 16;

    typedef enum logic [1:0] {
        OP_WR   = 2'd0,
        OP_RD   = 2'd1,
        OP_STEP = 2'd2
    } op_e;

    // One row of the stimulus table
    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [3:0]  cycles;
        logic        dor_a;
        logic        dor_b;
    } entry_t;

    entry_t             tbl[$];
    logic               clk;
    logic               rst_i;
    bb_pkg::apb_req_t   apb;
    bb_pkg::sample_t    adc_a;
    bb_pkg::sample_t    adc_b;
    logic               dor_a;
    logic               dor_b;
    wire [31:0]         prdata;
    bb_pkg::sample_t    dac_a;
    bb_pkg::sample_t    dac_b;
    wire [15:0]         adc_io;
    wire [15:0]         dac_io;
    int                 errors;
    // Model of the ctrl words by slot number
    logic [31:0]        model_ctrl [0:4];
    // Input history with d2 two edges back
    bb_pkg::sample_t    a_d1;
    bb_pkg::sample_t    a_d2;
    bb_pkg::sample_t    b_d1;
    bb_pkg::sample_t    b_d2;
    logic               dor_a_d1;
    logic               dor_a_d2;
    logic               dor_b_d1;
    logic               dor_b_d2;

    bb_top #(.PHASE_W(24)) dut_i (
        .clk(clk), .rst_i(rst_i), .apb_i(apb),
        .adc_a_i(adc_a), .adc_b_i(adc_b), .dor_a_i(dor_a), .dor_b_i(dor_b),
        .prdata_o(prdata), .dac_a_o(dac_a), .dac_b_o(dac_b),
        .adc_io_o(adc_io), .dac_io_o(dac_io)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        a_d1     <= adc_a;
        a_d2     <= a_d1;
        b_d1     <= adc_b;
        b_d2     <= b_d1;
        dor_a_d1 <= dor_a;
        dor_a_d2 <= dor_a_d1;
        dor_b_d1 <= dor_b;
        dor_b_d2 <= dor_b_d1;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] reg_addr(input logic [3:0] slot, input logic [11:0] ofs);
        return {16'h43C0, slot, ofs};
    endfunction

    // Expander byte built field by field from the channel ctrl word
    function automatic logic [7:0] expander_byte(input logic [31:0] ctrl, input logic dor);
        logic [7:0] b;
        b      = 8'h00;
        // Active low attenuator
        b[1:0] = ~ctrl[1:0];
        b[2]   = ctrl[2];
        // Active low LEDs, overrange lights red only
        b[5:3] = dor ? 3'b011 : ~ctrl[5:3];
        return b;
    endfunction

    function automatic bb_pkg::sample_t dac_expect(input logic [1:0] src,
                                                   input bb_pkg::sample_t a,
                                                   input bb_pkg::sample_t b);
        case (src)
            2'd0:    return a;
            2'd1:    return b;
            default: return 8'h00;
        endcase
    endfunction

    task automatic add_row(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                           input logic [31:0] exp, input int cycles,
                           input logic da, input logic db);
        entry_t e;
        e.op     = op;
        e.addr   = addr;
        e.data   = data;
        e.exp    = exp;
        e.cycles = 4'(cycles);
        e.dor_a  = da;
        e.dor_b  = db;
        tbl.push_back(e);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // Setup then access phase with read data taken in access
    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata);
        apb.paddr   = addr;
        apb.pwrite  = wr;
        apb.pwdata  = data;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        @(posedge clk);
        #1 apb.penable = 1'b1;
        #1 rdata = prdata;
        @(posedge clk);
        #1;
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused_rd;
        apb_xfer(1'b1, addr, data, unused_rd);
        // Only ctrl offsets inside the window hold state in the model
        if (addr[31:16] == 16'h43C0 && addr[15:12] < 4'd5 && addr[11:0] == 12'h000) begin
            model_ctrl[addr[15:12]] = data;
        end
    endtask

    task automatic apb_read_check(input logic [31:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        apb_xfer(1'b0, addr, 32'h0, rd);
        check_val($sformatf("prdata_o @%h", addr), exp, rd);
    endtask

    // Free-running cycles with random samples and data-path checks
    task automatic run_steps(input entry_t e);
        bb_pkg::sample_t prev_a;
        bb_pkg::sample_t prev_b;
        logic [7:0]      k;
        logic [1:0]      src_a;
        logic [1:0]      src_b;
        prev_a = dac_a;
        prev_b = dac_b;
        dor_a  = e.dor_a;
        dor_b  = e.dor_b;
        adc_a  = 8'($urandom());
        adc_b  = 8'($urandom());
        for (int i = 0; i < int'(e.cycles); i++) begin
            @(posedge clk);
            #1;
            src_a = model_ctrl[2][7:6];
            src_b = model_ctrl[3][7:6];
            k     = model_ctrl[4][23:16];
            // DDS sawtooth steps by k once the pipeline is full
            if (src_a == 2'd2) begin
                if (i >= 3) begin
                    check_val("dac_a_o step", 32'(k), 32'(8'(dac_a - prev_a)));
                end
            end else begin
                check_val("dac_a_o", 32'(dac_expect(src_a, a_d2, b_d2)), 32'(dac_a));
            end
            if (src_b == 2'd2) begin
                if (i >= 3) begin
                    check_val("dac_b_o step", 32'(k), 32'(8'(dac_b - prev_b)));
                end
            end else begin
                check_val("dac_b_o", 32'(dac_expect(src_b, a_d2, b_d2)), 32'(dac_b));
            end
            check_val("adc_io_o", {16'h0, expander_byte(model_ctrl[1], dor_b_d2),
                                   expander_byte(model_ctrl[0], dor_a_d2)}, 32'(adc_io));
            check_val("dac_io_o", {16'h0, expander_byte(model_ctrl[3], 1'b0),
                                   expander_byte(model_ctrl[2], 1'b0)}, 32'(dac_io));
            prev_a = dac_a;
            prev_b = dac_b;
            adc_a  = 8'($urandom());
            adc_b  = 8'($urandom());
        end
        dor_a = 1'b0;
        dor_b = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////////////////////////

    task automatic build_table();
        // Reset values
        add_row(OP_RD, reg_addr(4'd0, 12'h000), 0, 32'h0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd0, 12'h004), 0, 32'h0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd1, 12'h000), 0, 32'h0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd1, 12'h004), 0, 32'h0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd2, 12'h000), 0, 32'h0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd3, 12'h000), 0, 32'h0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd4, 12'h000), 0, 32'h0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd4, 12'h004), 0, 32'h0, 0, 0, 0);
        add_row(OP_STEP, 0, 0, 0, 5, 0, 0);
        // Register map and unmapped reads
        add_row(OP_WR, reg_addr(4'd0, 12'h000), 32'h2D, 0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd0, 12'h000), 0, 32'h2D, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd0, 12'h008), 0, 32'h0, 0, 0, 0);
        add_row(OP_WR, 32'h1234_0000, 32'hFF, 0, 0, 0, 0);
        add_row(OP_RD, 32'h1234_0000, 0, 32'h0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd5, 12'h000), 0, 32'h0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd15, 12'h000), 0, 32'h0, 0, 0, 0);
        add_row(OP_WR, reg_addr(4'd1, 12'h000), 32'h1E, 0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd1, 12'h000), 0, 32'h1E, 0, 0, 0);
        // OUTA from ADC B and OUTB silent
        add_row(OP_WR, reg_addr(4'd2, 12'h000), 32'h4A, 0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd2, 12'h000), 0, 32'h4A, 0, 0, 0);
        add_row(OP_WR, reg_addr(4'd3, 12'h000), 32'hC5, 0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd3, 12'h000), 0, 32'hC5, 0, 0, 0);
        add_row(OP_STEP, 0, 0, 0, 8, 0, 0);
        add_row(OP_WR, reg_addr(4'd2, 12'h000), 32'h07, 0, 0, 0, 0);
        add_row(OP_STEP, 0, 0, 0, 6, 0, 0);
        // DDS into OUTB
        add_row(OP_WR, reg_addr(4'd4, 12'h000), 32'h0003_0000, 0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd4, 12'h000), 0, 32'h0003_0000, 0, 0, 0);
        add_row(OP_WR, reg_addr(4'd3, 12'h000), 32'h80, 0, 0, 0, 0);
        add_row(OP_STEP, 0, 0, 0, 8, 0, 0);
        add_row(OP_WR, reg_addr(4'd4, 12'h000), 32'h00FD_0000, 0, 0, 0, 0);
        add_row(OP_STEP, 0, 0, 0, 7, 0, 0);
        // Overrange on A then on B
        add_row(OP_STEP, 0, 0, 0, 4, 1, 0);
        add_row(OP_STEP, 0, 0, 0, 3, 0, 0);
        add_row(OP_RD, reg_addr(4'd0, 12'h004), 0, 32'h1, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd1, 12'h004), 0, 32'h0, 0, 0, 0);
        add_row(OP_WR, reg_addr(4'd0, 12'h004), 32'h0, 0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd0, 12'h004), 0, 32'h0, 0, 0, 0);
        add_row(OP_STEP, 0, 0, 0, 4, 0, 1);
        add_row(OP_STEP, 0, 0, 0, 3, 0, 0);
        add_row(OP_RD, reg_addr(4'd1, 12'h004), 0, 32'h1, 0, 0, 0);
        add_row(OP_WR, reg_addr(4'd1, 12'h004), 32'h0, 0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd1, 12'h004), 0, 32'h0, 0, 0, 0);
        add_row(OP_WR, reg_addr(4'd5, 12'h000), 32'h33, 0, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd0, 12'h000), 0, 32'h2D, 0, 0, 0);
        add_row(OP_RD, reg_addr(4'd1, 12'h000), 0, 32'h1E, 0, 0, 0);
    endtask

    initial begin
        errors      = 0;
        void'($urandom(80932));
        rst_i       = 1'b1;
        apb         = '0;
        adc_a       = '0;
        adc_b       = '0;
        dor_a       = 1'b0;
        dor_b       = 1'b0;
        for (int s = 0; s < 5; s++) begin
            model_ctrl[s] = 32'h0;
        end
        build_table();
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_i = 1'b0;
        check_val("dac_a_o", 32'h0, 32'(dac_a));
        check_val("dac_b_o", 32'h0, 32'(dac_b));
        check_val("adc_io_o", 32'h3B3B, 32'(adc_io));
        check_val("dac_io_o", 32'h3B3B, 32'(dac_io));
        foreach (tbl[i]) begin
            case (tbl[i].op)
                OP_WR:   apb_write(tbl[i].addr, tbl[i].data);
                OP_RD:   apb_read_check(tbl[i].addr, tbl[i].exp);
                default: run_steps(tbl[i]);
            endcase
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog scaled by table length
    initial begin
        #1;
        #(20 * tbl.size() * CLK_NS);
        $display("Timeout: the test did not finish within %0d ns", 20 * tbl.size() * CLK_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/bb_adc_channel.sv */
`timescale 1ns/1ns
`default_nettype none

module bb_adc_channel (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire bb_pkg::slot_req_t   req_i,
    input  wire bb_pkg::sample_t     sample_i,
    input  wire                      dor_i,
    output logic [31:0]              rdata_o,
    output bb_pkg::sample_t          sample_o,
    output bb_pkg::chan_status_t     status_o
);

    bb_pkg::chan_ctrl_t ctrl_q;
    bb_pkg::sample_t    sample_q;
    logic               dor_q;
    logic               sticky_q;
    logic               ctrl_wr;
    logic               stat_wr;

    assign ctrl_wr = req_i.wr && req_i.ofs == bb_pkg::OFS_CTRL;
    // Any write to the status offset clears the sticky flag
    assign stat_wr = req_i.wr && req_i.ofs == bb_pkg::OFS_STAT;

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ctrl_q   <= '0;
            sample_q <= '0;
            dor_q    <= 1'b0;
            sticky_q <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                ctrl_q <= req_i.wdata.ctrl;
            end
            // Sample and overrange are free-running
            sample_q <= sample_i;
            dor_q    <= dor_i;
            // New overrange wins over a clear in the same cycle
            sticky_q <= (sticky_q && !stat_wr) || dor_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read back and outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rdata_o = '0;
        if (req_i.sel) begin
            case (req_i.ofs)
                bb_pkg::OFS_CTRL: rdata_o = ctrl_q;
                bb_pkg::OFS_STAT: rdata_o = {31'd0, sticky_q};
                default:          rdata_o = '0;
            endcase
        end
    end

    assign sample_o = sample_q;

    // Front-end settings plus the latched overrange
    assign status_o = '{dor: dor_q, led: ctrl_q.led, amp_en: ctrl_q.amp_en, att: ctrl_q.att};

endmodule

`default_nettype wire

/* verilog/bb_apb_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module bb_apb_decode (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire bb_pkg::apb_req_t    apb_i,
    input  wire [31:0]               rd_ina_i,
    input  wire [31:0]               rd_inb_i,
    input  wire [31:0]               rd_outa_i,
    input  wire [31:0]               rd_outb_i,
    input  wire [31:0]               rd_dds_i,
    output bb_pkg::slot_req_t        req_ina_o,
    output bb_pkg::slot_req_t        req_inb_o,
    output bb_pkg::slot_req_t        req_outa_o,
    output bb_pkg::slot_req_t        req_outb_o,
    output bb_pkg::slot_req_t        req_dds_o,
    output logic [31:0]              prdata_o
);

    logic       win_hit;
    logic [3:0] slot;
    logic       setup_q;
    logic       access;

    // Build one slot request, write strobe only in access phase
    function automatic bb_pkg::slot_req_t make_req(input logic hit, input logic acc,
                                                   input bb_pkg::apb_req_t apb);
        bb_pkg::slot_req_t r;
        r.sel       = hit && apb.psel;
        r.wr        = hit && acc && apb.pwrite;
        r.ofs       = apb.paddr[11:0];
        r.wdata.raw = apb.pwdata;
        return r;
    endfunction

    assign win_hit = apb_i.paddr[31:16] == bb_pkg::BASE_HI;
    assign slot    = apb_i.paddr[15:12];

    // Remember a setup phase so access is only the cycle after it
    always_ff @(posedge clk) begin
        if (rst_i) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= apb_i.psel && !apb_i.penable;
        end
    end

    assign access = apb_i.psel && apb_i.penable && setup_q;

    assign req_ina_o  = make_req(win_hit && slot == bb_pkg::SLOT_INA, access, apb_i);
    assign req_inb_o  = make_req(win_hit && slot == bb_pkg::SLOT_INB, access, apb_i);
    assign req_outa_o = make_req(win_hit && slot == bb_pkg::SLOT_OUTA, access, apb_i);
    assign req_outb_o = make_req(win_hit && slot == bb_pkg::SLOT_OUTB, access, apb_i);
    assign req_dds_o  = make_req(win_hit && slot == bb_pkg::SLOT_DDS, access, apb_i);

    // Read select, zero outside window or unmapped slot
    always_comb begin
        prdata_o = '0;
        if (access && win_hit) begin
            case (slot)
                bb_pkg::SLOT_INA:  prdata_o = rd_ina_i;
                bb_pkg::SLOT_INB:  prdata_o = rd_inb_i;
                bb_pkg::SLOT_OUTA: prdata_o = rd_outa_i;
                bb_pkg::SLOT_OUTB: prdata_o = rd_outb_i;
                bb_pkg::SLOT_DDS:  prdata_o = rd_dds_i;
                default:           prdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/bb_dac_channel.sv */
`timescale 1ns/1ns
`default_nettype none

module bb_dac_channel (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire bb_pkg::slot_req_t   req_i,
    input  wire bb_pkg::sample_t     ina_i,
    input  wire bb_pkg::sample_t     inb_i,
    input  wire bb_pkg::sample_t     dds_i,
    output logic [31:0]              rdata_o,
    output bb_pkg::sample_t          dac_o,
    output bb_pkg::chan_status_t     status_o
);

    bb_pkg::chan_ctrl_t ctrl_q;
    bb_pkg::sample_t    dac_q;
    logic               ctrl_wr;

    assign ctrl_wr = req_i.wr && req_i.ofs == bb_pkg::OFS_CTRL;

    //////////////////////////////////////////////////////////////////////
    // Ctrl register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ctrl_q <= '0;
        end else if (ctrl_wr) begin
            ctrl_q <= req_i.wdata.ctrl;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Source mux into the output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dac_q <= '0;
        end else begin
            case (ctrl_q.src)
                bb_pkg::SRC_INA:  dac_q <= ina_i;
                bb_pkg::SRC_INB:  dac_q <= inb_i;
                bb_pkg::SRC_DDS:  dac_q <= dds_i;
                // Silence
                bb_pkg::SRC_ZERO: dac_q <= '0;
            endcase
        end
    end

    assign dac_o = dac_q;

    // Only ctrl is mapped on output slots
    always_comb begin
        rdata_o = '0;
        if (req_i.sel && req_i.ofs == bb_pkg::OFS_CTRL) begin
            rdata_o = ctrl_q;
        end
    end

    // No overrange on the DAC side
    assign status_o = '{dor: 1'b0, led: ctrl_q.led, amp_en: ctrl_q.amp_en, att: ctrl_q.att};

endmodule

`default_nettype wire

/* verilog/bb_dds.sv */
`timescale 1ns/1ns
`default_nettype none

module bb_dds #(
    parameter int PHASE_W = 32
) (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire bb_pkg::slot_req_t   req_i,
    output logic [31:0]              rdata_o,
    output bb_pkg::sample_t          sample_o
);

    localparam int SAMPLE_W = $bits(bb_pkg::sample_t);

    // Raw increment kept whole for read back
    logic [31:0]        inc_q;
    logic [PHASE_W-1:0] phase_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            inc_q   <= '0;
            phase_q <= '0;
        end else begin
            if (req_i.wr && req_i.ofs == bb_pkg::OFS_CTRL) begin
                inc_q <= req_i.wdata.raw;
            end
            // Wraps modulo 2**PHASE_W
            phase_q <= phase_q + inc_q[PHASE_W-1:0];
        end
    end

    // Sawtooth from the top of the phase
    assign sample_o = phase_q[PHASE_W-1 -: SAMPLE_W];

    always_comb begin
        rdata_o = '0;
        if (req_i.sel) begin
            case (req_i.ofs)
                bb_pkg::OFS_CTRL: rdata_o = inc_q;
                // Phase zero extended
                bb_pkg::OFS_STAT: rdata_o = 32'(phase_q);
                default:          rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/bb_ioexp_result.sv */
`timescale 1ns/1ns
`default_nettype none

module bb_ioexp_result (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire bb_pkg::chan_status_t    ina_i,
    input  wire bb_pkg::chan_status_t    inb_i,
    input  wire bb_pkg::chan_status_t    outa_i,
    input  wire bb_pkg::chan_status_t    outb_i,
    output logic [15:0]                  adc_io_o,
    output logic [15:0]                  dac_io_o
);

    // Byte of an all-zero channel, att and LEDs are active low
    localparam logic [7:0] IDLE_BYTE = 8'h3B;

    // One expander byte per channel
    // bits 1:0 ~att, bit 2 amp_en, bits 5:3 ~led, 7:6 unused
    function automatic logic [7:0] io_byte(input bb_pkg::chan_status_t st);
        logic [2:0] led_v;
        // Overrange shows red only
        led_v = st.dor ? 3'b100 : st.led;
        return {2'b00, ~led_v, st.amp_en, ~st.att};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Expander words, channel A low byte, channel B high byte
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            adc_io_o <= {2{IDLE_BYTE}};
            dac_io_o <= {2{IDLE_BYTE}};
        end else begin
            adc_io_o <= {io_byte(inb_i), io_byte(ina_i)};
            dac_io_o <= {io_byte(outb_i), io_byte(outa_i)};
        end
    end

endmodule

`default_nettype wire

/* verilog/bb_pkg.sv */
`default_nettype none

package bb_pkg;

    //////////////////////////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////////////////////////

    // Window base 0x43C0_0000, compared on paddr[31:16]
    localparam logic [15:0] BASE_HI = 16'h43C0;

    // Slot number lives in paddr[15:12]
    localparam logic [3:0] SLOT_INA  = 4'd0;
    localparam logic [3:0] SLOT_INB  = 4'd1;
    localparam logic [3:0] SLOT_OUTA = 4'd2;
    localparam logic [3:0] SLOT_OUTB = 4'd3;
    localparam logic [3:0] SLOT_DDS  = 4'd4;

    // Byte offsets inside one slot
    localparam logic [11:0] OFS_CTRL = 12'h000;
    localparam logic [11:0] OFS_STAT = 12'h004;

    //////////////////////////////////////////////////////////////////////
    // Data types
    //////////////////////////////////////////////////////////////////////

    typedef logic [7:0] sample_t;

    // DAC source select
    typedef enum logic [1:0] {
        SRC_INA  = 2'd0,
        SRC_INB  = 2'd1,
        SRC_DDS  = 2'd2,
        SRC_ZERO = 2'd3
    } dac_src_e;

    // Channel ctrl word, att in the low bits
    typedef struct packed {
        logic [23:0] rsvd;
        dac_src_e    src;
        // Blue 0, green 1, red 2
        logic [2:0]  led;
        logic        amp_en;
        logic [1:0]  att;
    } chan_ctrl_t;

    // Same write word, channel view or DDS increment view
    typedef union packed {
        chan_ctrl_t  ctrl;
        logic [31:0] raw;
    } reg_word_u;

    typedef struct packed {
        logic [31:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    // Request as one register block sees it
    typedef struct packed {
        logic        sel;
        logic        wr;
        logic [11:0] ofs;
        reg_word_u   wdata;
    } slot_req_t;

    // Settings handed to the expander stage
    typedef struct packed {
        logic       dor;
        logic [2:0] led;
        logic       amp_en;
        logic [1:0] att;
    } chan_status_t;

endpackage

`default_nettype wire

/* verilog/bb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module bb_top #(
    // Accumulator width of the tone generator
    parameter int PHASE_W = 24
) (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire bb_pkg::apb_req_t    apb_i,
    input  wire bb_pkg::sample_t     adc_a_i,
    input  wire bb_pkg::sample_t     adc_b_i,
    input  wire                      dor_a_i,
    input  wire                      dor_b_i,
    output wire [31:0]               prdata_o,
    output wire bb_pkg::sample_t     dac_a_o,
    output wire bb_pkg::sample_t     dac_b_o,
    output wire [15:0]               adc_io_o,
    output wire [15:0]               dac_io_o
);

    //////////////////////////////////////////////////////////////////////
    // Interconnect
    //////////////////////////////////////////////////////////////////////

    bb_pkg::slot_req_t    req_ina;
    bb_pkg::slot_req_t    req_inb;
    bb_pkg::slot_req_t    req_outa;
    bb_pkg::slot_req_t    req_outb;
    bb_pkg::slot_req_t    req_dds;
    logic [31:0]          rd_ina;
    logic [31:0]          rd_inb;
    logic [31:0]          rd_outa;
    logic [31:0]          rd_outb;
    logic [31:0]          rd_dds;
    // Registered samples shared by both DACs
    bb_pkg::sample_t      ina_smp;
    bb_pkg::sample_t      inb_smp;
    bb_pkg::sample_t      dds_smp;
    bb_pkg::chan_status_t st_ina;
    bb_pkg::chan_status_t st_inb;
    bb_pkg::chan_status_t st_outa;
    bb_pkg::chan_status_t st_outb;

    bb_apb_decode u_decode (
        .clk(clk), .rst_i(rst_i), .apb_i(apb_i),
        .rd_ina_i(rd_ina), .rd_inb_i(rd_inb), .rd_outa_i(rd_outa),
        .rd_outb_i(rd_outb), .rd_dds_i(rd_dds),
        .req_ina_o(req_ina), .req_inb_o(req_inb), .req_outa_o(req_outa),
        .req_outb_o(req_outb), .req_dds_o(req_dds), .prdata_o(prdata_o)
    );

    // ADC inputs
    bb_adc_channel u_ina (
        .clk(clk), .rst_i(rst_i), .req_i(req_ina), .sample_i(adc_a_i), .dor_i(dor_a_i),
        .rdata_o(rd_ina), .sample_o(ina_smp), .status_o(st_ina)
    );

    bb_adc_channel u_inb (
        .clk(clk), .rst_i(rst_i), .req_i(req_inb), .sample_i(adc_b_i), .dor_i(dor_b_i),
        .rdata_o(rd_inb), .sample_o(inb_smp), .status_o(st_inb)
    );

    bb_dds #(.PHASE_W(PHASE_W)) u_dds (
        .clk(clk), .rst_i(rst_i), .req_i(req_dds), .rdata_o(rd_dds), .sample_o(dds_smp)
    );

    // DAC outputs
    bb_dac_channel u_outa (
        .clk(clk), .rst_i(rst_i), .req_i(req_outa),
        .ina_i(ina_smp), .inb_i(inb_smp), .dds_i(dds_smp),
        .rdata_o(rd_outa), .dac_o(dac_a_o), .status_o(st_outa)
    );

    bb_dac_channel u_outb (
        .clk(clk), .rst_i(rst_i), .req_i(req_outb),
        .ina_i(ina_smp), .inb_i(inb_smp), .dds_i(dds_smp),
        .rdata_o(rd_outb), .dac_o(dac_b_o), .status_o(st_outb)
    );

    bb_ioexp_result u_result (
        .clk(clk), .rst_i(rst_i),
        .ina_i(st_ina), .inb_i(st_inb), .outa_i(st_outa), .outb_i(st_outb),
        .adc_io_o(adc_io_o), .dac_io_o(dac_io_o)
    );

endmodule

`default_nettype wire
